//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= f2_savestate_tb
FILELIST  ?= f2_savestate.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- f2_savestate.f
+incdir+src
src/f2ss_pkg.sv
src/cpu_bus_if.sv
src/ss_window_decode.sv
src/ss_timer.sv
src/ss_sequencer.sv
src/ss_cpu_data.sv
src/irq_ctrl.sv
src/f2_savestate.sv
testbench/storage_model.sv
testbench/f2_savestate_tb.sv

//--- src/cpu_bus_if.sv
`timescale 1ns/1ns

interface cpu_bus_if;
    import f2ss_pkg::*;

    // 68000 bus cycle as seen by the controller
    byte_addr_t addr;
    logic [1:0] ds_n;   // Upper, lower strobe
    logic       rw;     // 1 is read
    cpu_fc_t    fc;
    word_t      dout;   // CPU write data

    modport monitor (
        input addr,
        input ds_n,
        input rw,
        input fc,
        input dout
    );
endinterface

interface ss_hit_if;
    // Save-state window hits, combinational from the bus
    logic ssp_hi_wr;
    logic ssp_lo_wr;
    logic handler_sel;
    logic vector_sel;
    logic resetvec_sel;
    logic prog_exit;    // Supervisor fetch outside all windows

    modport source (
        output ssp_hi_wr,
        output ssp_lo_wr,
        output handler_sel,
        output vector_sel,
        output resetvec_sel,
        output prog_exit
    );

    modport sink (
        input ssp_hi_wr,
        input ssp_lo_wr,
        input handler_sel,
        input vector_sel,
        input resetvec_sel,
        input prog_exit
    );
endinterface

//--- src/f2_savestate.sv
`timescale 1ns/1ns

module f2_savestate (
    input  logic                clk,
    input  logic                reset,

    input  f2ss_pkg::byte_addr_t cpu_addr,
    input  logic [1:0]          cpu_ds_n,
    input  logic                cpu_rw,
    input  f2ss_pkg::cpu_fc_t   cpu_fc,
    input  f2ss_pkg::word_t     cpu_dout,
    input  f2ss_pkg::word_t     mem_data,
    output f2ss_pkg::word_t     cpu_din,
    output f2ss_pkg::ipl_t      ipl_n,
    output logic                cpu_pause,
    output logic                cpu_reset,

    input  logic                vblank_n,
    input  logic                dma_n,

    input  logic                ss_do_save,
    input  logic                ss_do_restore,
    output logic                ss_write,
    output logic                ss_read,
    input  logic                ss_busy,
    output f2ss_pkg::ssp_t      ss_saved_ssp,
    input  f2ss_pkg::ssp_t      ss_restore_ssp,
    output f2ss_pkg::ss_state_t ss_state
);

    cpu_bus_if bus ();
    ss_hit_if  hit ();

    logic override;
    logic reset_phase;
    logic timer_clear;
    logic settle_done;
    logic hold_done;
    logic capture_hi;
    logic capture_lo;
    logic load_vector;
    logic cpu_reset_req;

    assign bus.addr = cpu_addr;
    assign bus.ds_n = cpu_ds_n;
    assign bus.rw   = cpu_rw;
    assign bus.fc   = cpu_fc;
    assign bus.dout = cpu_dout;

    assign cpu_reset = reset | cpu_reset_req;

    ////////////////////////////////////////////////////////////////////////////
    // Save-state controller

    ss_window_decode u_decode (
        .bus         (bus),
        .override    (override),
        .reset_phase (reset_phase),
        .hit         (hit)
    );

    ss_timer u_timer (
        .clk         (clk),
        .reset       (reset),
        .clear       (timer_clear),
        .settle_done (settle_done),
        .hold_done   (hold_done)
    );

    ss_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .ss_do_save    (ss_do_save),
        .ss_do_restore (ss_do_restore),
        .ss_busy       (ss_busy),
        .hit           (hit),
        .settle_done   (settle_done),
        .hold_done     (hold_done),
        .timer_clear   (timer_clear),
        .capture_hi    (capture_hi),
        .capture_lo    (capture_lo),
        .load_vector   (load_vector),
        .override      (override),
        .reset_phase   (reset_phase),
        .cpu_pause     (cpu_pause),
        .cpu_reset_req (cpu_reset_req),
        .ss_write      (ss_write),
        .ss_read       (ss_read),
        .state         (ss_state)
    );

    ss_cpu_data u_cpu_data (
        .clk         (clk),
        .bus         (bus),
        .hit         (hit),
        .capture_hi  (capture_hi),
        .capture_lo  (capture_lo),
        .load_vector (load_vector),
        .restore_ssp (ss_restore_ssp),
        .mem_data    (mem_data),
        .saved_ssp   (ss_saved_ssp),
        .cpu_din     (cpu_din)
    );

    // Interrupts
    irq_ctrl u_irq (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .vblank_n   (vblank_n),
        .dma_n      (dma_n),
        .ss_do_save (ss_do_save),
        .ipl_n      (ipl_n)
    );

endmodule

//--- src/f2ss_defs.svh
`ifndef F2SS_DEFS_SVH
`define F2SS_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Sequencer timing

`define SS_SETTLE_CYCLES      64    // Pause before storage start
`define SS_RESET_HOLD_CYCLES  1000
`define SS_TIMER_W            16

////////////////////////////////////////////////////////////////////////////
// Save-state address map

`define SSP_HI_ADDR           24'hff0000
`define SSP_LO_ADDR           24'hff0002
`define HANDLER_BASE          24'hff0000
`define HANDLER_WORDS         13
`define L7_VECTOR_ADDR        24'h00007c  // Level-7 autovector, two words
`define RESET_VECTOR_WORDS    4
`define RESET_PC_HI           16'h00ff
`define RESET_PC_LO           16'h0008

// Interrupt levels
`define IPL_VBL               3'd5
`define IPL_DMA               3'd6
`define IPL_SAVE              3'd7

`endif

//--- src/f2ss_pkg.sv
`include "f2ss_defs.svh"

package f2ss_pkg;

    typedef logic [15:0] word_t;
    typedef logic [23:0] byte_addr_t;
    typedef logic [31:0] ssp_t;
    typedef logic [2:0]  ipl_t;

    typedef enum logic [3:0] {
        SST_IDLE,
        SST_START_SAVE,
        SST_WAIT_SAVE,
        SST_SAVE_PAUSED_SETTLE,
        SST_SAVE_PAUSED,
        SST_WAIT_SAVE_HANDLER,
        SST_RESTORE_SETTLE,
        SST_WAIT_RESTORE,
        SST_HOLD_RESET,
        SST_WAIT_RESET
    } ss_state_t;

    // 68000 function codes
    typedef enum logic [2:0] {
        FC_USER_DATA  = 3'd1,
        FC_USER_PROG  = 3'd2,
        FC_SUPER_DATA = 3'd5,
        FC_SUPER_PROG = 3'd6,
        FC_INT_ACK    = 3'd7
    } cpu_fc_t;

    // Level-7 handler, pushes all regs and parks SSP at ff0000
    localparam word_t SAVE_HANDLER [`HANDLER_WORDS] = '{
        16'h48e7, 16'hfffe, 16'h4e6e, 16'h2f0e,
        16'h4df9, 16'h00ff, 16'h0000, 16'h2c8f,  // Restart point at +8
        16'h2c5f, 16'h4e66, 16'h4cdf, 16'h7fff,
        16'h4e73                                 // rte
    };

endpackage

//--- src/irq_ctrl.sv
`timescale 1ns/1ns
`include "f2ss_defs.svh"

module irq_ctrl (
    input  logic           clk,
    input  logic           reset,
    cpu_bus_if.monitor     bus,
    input  logic           vblank_n,
    input  logic           dma_n,
    input  logic           ss_do_save,
    output f2ss_pkg::ipl_t ipl_n
);
    import f2ss_pkg::*;

    // Source order is vblank, DMA, save
    localparam ipl_t SRC_LEVEL [3] = '{`IPL_VBL, `IPL_DMA, `IPL_SAVE};

    logic [2:0] src;
    logic [2:0] src_q;
    logic [2:0] src_qq;
    logic [2:0] rise;
    logic [2:0] ack;
    logic [2:0] req;

    // All three as rising edges
    assign src  = {ss_do_save, dma_n, ~vblank_n};
    assign rise = src_q & ~src_qq;

    // Acknowledge cycle on the lower strobe
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            ack[i] = (bus.fc == FC_INT_ACK) && !bus.ds_n[0]
                  && (bus.addr[3:1] == SRC_LEVEL[i]);
        end
    end

    always_ff @(posedge clk) begin
        src_q <= src;
        if (reset) begin
            src_qq <= src;      // No edge out of reset
            req    <= '0;
        end else begin
            src_qq <= src_q;
            req    <= (req | rise) & ~ack;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Priority encoder

    always_comb begin
        if (req[2]) begin
            ipl_n = ~SRC_LEVEL[2];
        end else if (req[1]) begin
            ipl_n = ~SRC_LEVEL[1];
        end else if (req[0]) begin
            ipl_n = ~SRC_LEVEL[0];
        end else begin
            ipl_n = '1;
        end
    end

endmodule

//--- src/ss_cpu_data.sv
`timescale 1ns/1ns
`include "f2ss_defs.svh"

module ss_cpu_data (
    input  logic            clk,
    cpu_bus_if.monitor      bus,
    ss_hit_if.sink          hit,
    input  logic            capture_hi,
    input  logic            capture_lo,
    input  logic            load_vector,
    input  f2ss_pkg::ssp_t  restore_ssp,
    input  f2ss_pkg::word_t mem_data,
    output f2ss_pkg::ssp_t  saved_ssp,
    output f2ss_pkg::word_t cpu_din
);
    import f2ss_pkg::*;

    word_t      reset_vector [`RESET_VECTOR_WORDS];
    logic [3:0] handler_idx;
    logic [1:0] resetvec_idx;

    assign handler_idx  = bus.addr[4:1];    // Handler base is 32-byte aligned
    assign resetvec_idx = bus.addr[2:1];

    ////////////////////////////////////////////////////////////////////////////
    // Captured and restored stack pointer

    always_ff @(posedge clk) begin
        if (capture_hi) saved_ssp[31:16] <= bus.dout;
        if (capture_lo) saved_ssp[15:0]  <= bus.dout;

        if (load_vector) begin
            reset_vector[0] <= restore_ssp[31:16];
            reset_vector[1] <= restore_ssp[15:0];
            reset_vector[2] <= `RESET_PC_HI;
            reset_vector[3] <= `RESET_PC_LO;    // Restart inside the handler
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data override

    always_comb begin
        if (hit.handler_sel) begin
            cpu_din = SAVE_HANDLER[handler_idx];
        end else if (hit.resetvec_sel) begin
            cpu_din = reset_vector[resetvec_idx];
        end else if (hit.vector_sel) begin
            cpu_din = bus.addr[1] ? 16'h0000 : 16'h00ff;   // Vector points at ff0000
        end else begin
            cpu_din = mem_data;
        end
    end

endmodule

//--- src/ss_sequencer.sv
`timescale 1ns/1ns

module ss_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                ss_do_save,
    input  logic                ss_do_restore,
    input  logic                ss_busy,
    ss_hit_if.sink              hit,
    input  logic                settle_done,
    input  logic                hold_done,
    output logic                timer_clear,
    output logic                capture_hi,
    output logic                capture_lo,
    output logic                load_vector,
    output logic                override,
    output logic                reset_phase,
    output logic                cpu_pause,
    output logic                cpu_reset_req,
    output logic                ss_write,
    output logic                ss_read,
    output f2ss_pkg::ss_state_t state
);
    import f2ss_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Event strobes

    assign capture_hi = (state == SST_START_SAVE) && hit.ssp_hi_wr;
    assign capture_lo = (state == SST_WAIT_SAVE) && hit.ssp_lo_wr;

    // Storage read finished, build the reset vector
    assign load_vector = (state == SST_WAIT_RESTORE) && !ss_busy && !ss_read;

    // Timer restarts on entry to a timed state
    assign timer_clear = ((state == SST_IDLE) && ss_do_restore) || capture_lo || load_vector;

    ////////////////////////////////////////////////////////////////////////////
    // State register and storage start levels

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= SST_IDLE;
            ss_write <= 1'b0;
            ss_read  <= 1'b0;
        end else begin
            case (state)
                SST_IDLE: begin
                    if (ss_do_restore) begin
                        state <= SST_RESTORE_SETTLE;
                    end else if (ss_do_save) begin
                        state <= SST_START_SAVE;
                    end
                end

                SST_START_SAVE: begin
                    if (capture_hi) state <= SST_WAIT_SAVE;
                end

                SST_WAIT_SAVE: begin
                    if (capture_lo) state <= SST_SAVE_PAUSED_SETTLE;
                end

                SST_SAVE_PAUSED_SETTLE: begin
                    if (settle_done) begin
                        ss_write <= 1'b1;
                        state    <= SST_SAVE_PAUSED;
                    end
                end

                SST_SAVE_PAUSED: begin
                    if (ss_busy && ss_write) begin
                        ss_write <= 1'b0;           // Engine has taken the start
                    end else if (!ss_busy && !ss_write) begin
                        state <= SST_WAIT_SAVE_HANDLER;
                    end
                end

                SST_WAIT_SAVE_HANDLER: begin
                    if (hit.prog_exit) state <= SST_IDLE;
                end

                SST_RESTORE_SETTLE: begin
                    if (settle_done) begin
                        ss_read <= 1'b1;
                        state   <= SST_WAIT_RESTORE;
                    end
                end

                SST_WAIT_RESTORE: begin
                    if (ss_busy && ss_read) begin
                        ss_read <= 1'b0;
                    end else if (load_vector) begin
                        state <= SST_HOLD_RESET;
                    end
                end

                SST_HOLD_RESET: begin
                    if (hold_done) state <= SST_WAIT_RESET;
                end

                SST_WAIT_RESET: begin
                    if (hit.prog_exit) state <= SST_IDLE;
                end

                default: state <= SST_IDLE;
            endcase
        end
    end

    // Mode levels
    assign override      = (state != SST_IDLE);
    assign reset_phase   = (state == SST_HOLD_RESET) || (state == SST_WAIT_RESET);
    assign cpu_pause     = (state == SST_SAVE_PAUSED_SETTLE) || (state == SST_SAVE_PAUSED)
                        || (state == SST_WAIT_RESTORE);
    assign cpu_reset_req = (state == SST_RESTORE_SETTLE) || (state == SST_HOLD_RESET);

endmodule

//--- src/ss_timer.sv
`timescale 1ns/1ns
`include "f2ss_defs.svh"

module ss_timer (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    output logic settle_done,
    output logic hold_done
);

    logic [`SS_TIMER_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;        // Zero in the first cycle of the new state
        end else begin
            count <= count + 1'b1;
        end
    end

    assign settle_done = (count == `SS_TIMER_W'(`SS_SETTLE_CYCLES));
    assign hold_done   = (count == `SS_TIMER_W'(`SS_RESET_HOLD_CYCLES));

endmodule

//--- src/ss_window_decode.sv
`timescale 1ns/1ns
`include "f2ss_defs.svh"

module ss_window_decode (
    cpu_bus_if.monitor bus,
    input  logic       override,
    input  logic       reset_phase,
    ss_hit_if.source   hit
);
    import f2ss_pkg::*;

    localparam byte_addr_t HANDLER_START = `HANDLER_BASE;
    localparam byte_addr_t HANDLER_END   = byte_addr_t'(`HANDLER_BASE + 2 * `HANDLER_WORDS);
    localparam byte_addr_t L7_VECTOR     = `L7_VECTOR_ADDR;
    localparam byte_addr_t RESETVEC_END  = byte_addr_t'(2 * `RESET_VECTOR_WORDS);

    logic rd_cycle;
    logic word_wr;
    logic handler_hit;
    logic vector_hit;
    logic resetvec_hit;

    assign rd_cycle = bus.rw && (bus.ds_n != 2'b11);
    assign word_wr  = !bus.rw && (bus.ds_n == 2'b00);

    // Stack pointer halves written by the handler
    assign hit.ssp_hi_wr = word_wr && (bus.addr == `SSP_HI_ADDR);
    assign hit.ssp_lo_wr = word_wr && (bus.addr == `SSP_LO_ADDR);

    ////////////////////////////////////////////////////////////////////////////
    // Read windows, each gated by the controller mode

    assign handler_hit = rd_cycle && override
                      && (bus.addr >= HANDLER_START) && (bus.addr < HANDLER_END);

    assign vector_hit = rd_cycle && override
                     && (bus.addr[23:2] == L7_VECTOR[23:2]);   // Both words of the pair

    assign resetvec_hit = rd_cycle && reset_phase && (bus.addr < RESETVEC_END);

    assign hit.handler_sel  = handler_hit;
    assign hit.vector_sel   = vector_hit;
    assign hit.resetvec_sel = resetvec_hit;

    // First normal fetch marks the end of a sequence
    assign hit.prog_exit = bus.rw && (bus.ds_n == 2'b00) && (bus.fc == FC_SUPER_PROG)
                        && !handler_hit && !vector_hit && !resetvec_hit;

endmodule

//--- testbench/f2_savestate_tb.sv
`timescale 1ns/1ns
`include "f2ss_defs.svh"

module f2_savestate_tb;
    import f2ss_pkg::*;

    localparam int CLK_PERIOD     = 10;
    localparam int STORAGE_MAX    = 20 + 40;    // Longest start delay plus busy
    localparam int IRQ_CYCLES     = 60;
    localparam int SAVE_CYCLES    = 120 + `SS_SETTLE_CYCLES + 1 + STORAGE_MAX;
    localparam int RESTORE_CYCLES = 60 + `SS_SETTLE_CYCLES + 1 + STORAGE_MAX
                                  + `SS_RESET_HOLD_CYCLES + 1;
    localparam int TIMEOUT_CYCLES = 2 * (IRQ_CYCLES + SAVE_CYCLES + RESTORE_CYCLES);

    localparam ssp_t       SAVE_SSP    = 32'h00ff_f3c0;
    localparam ssp_t       RESTORE_SSP = 32'h00fe_8a24;
    localparam byte_addr_t EXIT_PC     = 24'h000400;   // Normal code outside all windows

    logic       clk = 1'b0;
    logic       reset;
    byte_addr_t cpu_addr;
    logic [1:0] cpu_ds_n;
    logic       cpu_rw;
    cpu_fc_t    cpu_fc;
    word_t      cpu_dout;
    word_t      mem_data;
    word_t      cpu_din;
    ipl_t       ipl_n;
    logic       cpu_pause;
    logic       cpu_reset;
    logic       vblank_n;
    logic       dma_n;
    logic       ss_do_save;
    logic       ss_do_restore;
    logic       ss_write;
    logic       ss_read;
    logic       ss_busy;
    ssp_t       ss_saved_ssp;
    ssp_t       ss_restore_ssp;
    ss_state_t  ss_state;

    int   errors = 0;
    int   checks = 0;
    logic exp_override = 1'b0;
    logic exp_reset_phase = 1'b0;

    f2_savestate UUT (.*);
    storage_model u_storage (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Work RAM contents as a pattern over the whole address
    assign mem_data = cpu_addr[15:0] ^ {cpu_addr[23:16], cpu_addr[23:16]} ^ 16'h5aa5;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and compare tasks

    function automatic word_t ref_din(input byte_addr_t addr, input logic ovr,
                                      input logic rst_phase, input ssp_t rssp,
                                      input word_t mem);
        byte_addr_t offset;
        word_t      result;

        offset = addr - `HANDLER_BASE;   // Wraps high below the handler window
        result = mem;
        if (rst_phase && (addr < byte_addr_t'(2 * `RESET_VECTOR_WORDS))) begin
            case (addr[2:1])
                2'd0:    result = rssp[31:16];
                2'd1:    result = rssp[15:0];
                2'd2:    result = `RESET_PC_HI;
                default: result = `RESET_PC_LO;
            endcase
        end else if (ovr && (offset < byte_addr_t'(2 * `HANDLER_WORDS))) begin
            result = SAVE_HANDLER[offset[4:1]];
        end else if (ovr && (addr == `L7_VECTOR_ADDR)) begin
            result = 16'h00ff;                  // Handler entry at ff0000
        end else if (ovr && (addr == byte_addr_t'(`L7_VECTOR_ADDR + 2))) begin
            result = 16'h0000;
        end
        return result;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ipl(input ipl_t got, input ipl_t exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_ssp(input ssp_t got, input ssp_t exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_state(input ss_state_t got, input ss_state_t exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: %s is %s, expected %s", $time, what,
                     got.name(), exp.name());
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks = checks + 1;
        if (got != exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus cycles of one clock each

    task automatic cpu_read(input byte_addr_t addr, input cpu_fc_t fc);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_ds_n <= 2'b00;
        cpu_rw   <= 1'b1;
        cpu_fc   <= fc;
        @(posedge clk);
        cpu_ds_n <= 2'b11;
    endtask

    task automatic cpu_write(input byte_addr_t addr, input word_t data);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_ds_n <= 2'b00;
        cpu_rw   <= 1'b0;
        cpu_fc   <= FC_SUPER_DATA;
        cpu_dout <= data;
        @(posedge clk);
        cpu_ds_n <= 2'b11;
        cpu_rw   <= 1'b1;
    endtask

    // Level on address bits 3..1
    task automatic int_ack(input ipl_t level);
        cpu_read({20'hfffff, level, 1'b1}, FC_INT_ACK);
    endtask

    // Every active read is compared mid-cycle
    always @(negedge clk) begin
        if (!reset && cpu_rw && (cpu_ds_n != 2'b11)) begin
            check_word(cpu_din, ref_din(cpu_addr, exp_override, exp_reset_phase,
                                        ss_restore_ssp, mem_data),
                       $sformatf("cpu_din at %h", cpu_addr));
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: no result after %0d cycles, the DUT stopped responding",
                 TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        int n;

        reset          <= 1'b1;
        cpu_addr       <= '0;
        cpu_ds_n       <= 2'b11;
        cpu_rw         <= 1'b1;
        cpu_fc         <= FC_USER_DATA;
        cpu_dout       <= '0;
        vblank_n       <= 1'b1;
        dma_n          <= 1'b0;
        ss_do_save     <= 1'b0;
        ss_do_restore  <= 1'b0;
        ss_restore_ssp <= RESTORE_SSP;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        ////////////////////////////////////////////////////////////////////////////
        // Idle reads and the interrupt encoder

        cpu_read(24'h012344, FC_USER_DATA);
        cpu_read(24'hff0004, FC_SUPER_DATA);     // Handler window closed in idle
        cpu_read(`L7_VECTOR_ADDR, FC_SUPER_DATA);
        vblank_n <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_ipl(ipl_n, ~`IPL_VBL, "IPL after vblank");
        @(posedge clk);
        dma_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_ipl(ipl_n, ~`IPL_DMA, "IPL after DMA");
        int_ack(`IPL_DMA);
        @(negedge clk);
        check_ipl(ipl_n, ~`IPL_VBL, "IPL after level-6 acknowledge");
        int_ack(`IPL_VBL);
        @(negedge clk);
        check_ipl(ipl_n, 3'b111, "IPL after level-5 acknowledge");

        ////////////////////////////////////////////////////////////////////////////
        // Save sequence

        @(posedge clk);
        vblank_n   <= 1'b1;
        dma_n      <= 1'b0;
        ss_do_save <= 1'b1;
        @(posedge clk);
        ss_do_save <= 1'b0;
        @(negedge clk);
        check_state(ss_state, SST_START_SAVE, "state after save request");
        check_ipl(ipl_n, 3'b111, "IPL one cycle after save request");
        exp_override = 1'b1;
        @(negedge clk);
        check_ipl(ipl_n, ~`IPL_SAVE, "IPL two cycles after save request");
        cpu_read(`L7_VECTOR_ADDR, FC_SUPER_DATA);
        cpu_read(byte_addr_t'(`L7_VECTOR_ADDR + 2), FC_SUPER_DATA);
        for (int i = 0; i < `HANDLER_WORDS; i++) begin
            cpu_read(byte_addr_t'(`HANDLER_BASE + 2 * i), FC_SUPER_PROG);
        end

        cpu_write(`SSP_HI_ADDR, SAVE_SSP[31:16]);
        @(negedge clk);
        check_state(ss_state, SST_WAIT_SAVE, "state after SSP high write");
        cpu_write(`SSP_LO_ADDR, SAVE_SSP[15:0]);
        @(negedge clk);
        check_ssp(ss_saved_ssp, SAVE_SSP, "saved SSP");
        check_state(ss_state, SST_SAVE_PAUSED_SETTLE, "state after SSP low write");
        check_flag(cpu_pause, 1'b1, "cpu_pause in settle");
        n = 0;
        while (!ss_write) begin
            n = n + 1;
            @(negedge clk);
        end
        check_count(n, `SS_SETTLE_CYCLES + 1, "save settle cycles");
        while (!ss_busy) begin
            check_flag(cpu_pause, 1'b1, "cpu_pause before busy");
            @(negedge clk);
        end
        while (ss_busy) begin
            check_flag(cpu_pause, 1'b1, "cpu_pause while busy");
            @(negedge clk);
        end
        check_flag(cpu_pause, 1'b1, "cpu_pause as busy falls");
        @(negedge clk);
        check_state(ss_state, SST_WAIT_SAVE_HANDLER, "state after storage write");
        check_flag(cpu_pause, 1'b0, "cpu_pause after storage write");

        cpu_read(EXIT_PC, FC_SUPER_PROG);
        @(negedge clk);
        check_state(ss_state, SST_IDLE, "state after handler exit");
        exp_override = 1'b0;
        int_ack(`IPL_SAVE);
        @(negedge clk);
        check_ipl(ipl_n, 3'b111, "IPL after level-7 acknowledge");

        ////////////////////////////////////////////////////////////////////////////
        // Restore sequence

        @(posedge clk);
        ss_do_restore <= 1'b1;
        @(posedge clk);
        ss_do_restore <= 1'b0;
        @(negedge clk);
        check_state(ss_state, SST_RESTORE_SETTLE, "state after restore request");
        check_flag(cpu_reset, 1'b1, "cpu_reset in restore settle");
        exp_override = 1'b1;
        n = 0;
        while (!ss_read) begin
            n = n + 1;
            @(negedge clk);
        end
        check_count(n, `SS_SETTLE_CYCLES + 1, "restore settle cycles");
        check_state(ss_state, SST_WAIT_RESTORE, "state at storage read");
        check_flag(cpu_pause, 1'b1, "cpu_pause during storage read");
        while (!cpu_reset) @(negedge clk);
        n = 0;
        while (cpu_reset) begin
            n = n + 1;
            @(negedge clk);
        end
        check_count(n, `SS_RESET_HOLD_CYCLES + 1, "reset hold cycles");
        check_state(ss_state, SST_WAIT_RESET, "state after reset hold");
        exp_reset_phase = 1'b1;
        for (int i = 0; i < `RESET_VECTOR_WORDS; i++) begin
            cpu_read(byte_addr_t'(2 * i), FC_SUPER_PROG);
        end
        cpu_read(EXIT_PC, FC_SUPER_PROG);
        @(negedge clk);
        check_state(ss_state, SST_IDLE, "state after restart fetch");
        exp_override = 1'b0;
        exp_reset_phase = 1'b0;
        cpu_read(24'h000004, FC_SUPER_DATA);     // Reset vector window closed again

        repeat (2) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- testbench/storage_model.sv
`timescale 1ns/1ns

module storage_model (
    input  logic clk,
    input  logic reset,
    input  logic ss_write,
    input  logic ss_read,
    output logic ss_busy
);

    integer seed;
    int     start_delay;
    int     busy_len;

    // Each start level is answered by one busy pulse
    initial begin
        seed = 68068;
        ss_busy <= 1'b0;
        forever begin
            @(posedge clk);
            if (!reset && (ss_write || ss_read)) begin
                start_delay = 3 + ({$random(seed)} % 18);    // 3 to 20 cycles after start
                busy_len    = 10 + ({$random(seed)} % 31);   // 10 to 40 cycles
                repeat (start_delay - 1) @(posedge clk);
                ss_busy <= 1'b1;
                repeat (busy_len) @(posedge clk);
                ss_busy <= 1'b0;
            end
        end
    end

endmodule
